//--- tb.f
rtl/keypad_pkg.sv
rtl/lock_pkg.sv
rtl/keypad_decoder.sv
rtl/code_entry.sv
rtl/lockout_timer.sv
rtl/buzzer_tone.sv
rtl/lock_top.sv
dv/lock_asserts.sv
dv/tb_lock.sv

//--- dv/tb_lock.sv
`timescale 1ns/10ps

module tb_lock;

    localparam int unsigned TICK_DIV     = 20;
    localparam int unsigned LOCKOUT_SECS = 3;
    localparam int unsigned MAX_TRIES    = 3;
    localparam logic [11:0] DEFAULT_CODE = 12'h246;
    localparam int unsigned TONE_HALF    = 4;
    localparam int unsigned BEEP_LEN     = 40;
    localparam logic [7:0]  SECS_BCD     = 8'h03; // three seconds in BCD

    logic               clk;
    logic               reset;
    logic [15:0]        onehot;
    lock_pkg::display_t display;
    logic [3:0]         tries;
    logic               unlocked;
    logic               buzzer;

    // reference model state
    lock_pkg::lock_state_e exp_mode;
    logic [2:0][3:0]       exp_buf;   // [0] newest digit
    int                    exp_count;
    int                    exp_tries;
    logic                  exp_unlocked;
    logic [11:0]           exp_code;
    logic [31:0]           rng_state;
    logic [11:0]           old_code;
    logic [11:0]           new_code;

    lock_top #(
        .TICK_DIV     (TICK_DIV),
        .LOCKOUT_SECS (LOCKOUT_SECS),
        .MAX_TRIES    (MAX_TRIES),
        .DEFAULT_CODE (DEFAULT_CODE),
        .TONE_HALF    (TONE_HALF),
        .BEEP_LEN     (BEEP_LEN)
    ) lock_top_inst (
        .clk      (clk),
        .reset    (reset),
        .onehot   (onehot),
        .display  (display),
        .tries    (tries),
        .unlocked (unlocked),
        .buzzer   (buzzer)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    task automatic report_fail(input string msg);
        $display("Fail at %0t ns: %s", $time, msg);
        $display("tests failed");
        $fatal(1, "value mismatch");
    endtask

    task automatic report_timeout(input string what);
        $display("timed out waiting for %s", what);
        $display("tests failed");
        $fatal(1, "timeout");
    endtask

    task automatic check_outputs(input string where);
        assert (display.mode == exp_mode) else report_fail($sformatf(
            "%s: mode %0d, expected %0d", where, display.mode, exp_mode));
        assert (display.count == exp_count) else report_fail($sformatf(
            "%s: count %0d, expected %0d", where, display.count, exp_count));
        assert (tries == exp_tries) else report_fail($sformatf(
            "%s: tries %0d, expected %0d", where, tries, exp_tries));
        assert (unlocked == exp_unlocked) else report_fail($sformatf(
            "%s: unlocked %0b, expected %0b", where, unlocked, exp_unlocked));
        if (exp_mode != lock_pkg::ST_LOCKOUT) begin
            assert (display.digit == exp_buf) else report_fail($sformatf(
                "%s: digits %h, expected %h", where, display.digit, exp_buf));
        end
    endtask

    // expected effect of one key, tone is set when a beep should follow
    task automatic model_key(input int key, output logic tone);
        logic typing;
        typing = (exp_mode == lock_pkg::ST_ENTRY) || (exp_mode == lock_pkg::ST_SET);
        tone = 1'b0;
        if (exp_mode != lock_pkg::ST_LOCKOUT) begin
            if (typing && key <= 9) begin
                if (exp_count < 3) begin
                    exp_buf = {exp_buf[1:0], 4'(key)};
                    exp_count++;
                end
                tone = 1'b1;
            end else if (typing && key == keypad_pkg::KEY_BACK) begin
                exp_buf = {4'h0, exp_buf[2:1]};
                if (exp_count != 0) begin
                    exp_count--;
                end
                tone = 1'b1;
            end else if (typing && key == keypad_pkg::KEY_ENTER && exp_count == 3) begin
                tone = 1'b1;
                if (exp_mode == lock_pkg::ST_SET) begin
                    exp_code = exp_buf;
                    exp_mode = lock_pkg::ST_OPEN;
                end else if (exp_buf == exp_code) begin
                    exp_mode     = lock_pkg::ST_OPEN;
                    exp_tries    = 0;
                    exp_unlocked = 1'b1;
                end else if (exp_tries + 1 == MAX_TRIES) begin
                    exp_mode  = lock_pkg::ST_LOCKOUT;
                    exp_tries = 0;
                end else begin
                    exp_tries++;
                end
                exp_buf   = '0;
                exp_count = 0;
            end else if (key == keypad_pkg::KEY_CLEAR) begin
                tone      = 1'b1;
                exp_buf   = '0;
                exp_count = 0;
                if (exp_mode == lock_pkg::ST_ENTRY) begin
                    exp_tries = 0;
                end else if (exp_mode == lock_pkg::ST_OPEN) begin
                    exp_mode     = lock_pkg::ST_ENTRY;
                    exp_unlocked = 1'b0;
                end else begin
                    exp_mode = lock_pkg::ST_OPEN;
                end
            end else if (key == keypad_pkg::KEY_SET && exp_mode == lock_pkg::ST_OPEN) begin
                tone      = 1'b1;
                exp_mode  = lock_pkg::ST_SET;
                exp_buf   = '0;
                exp_count = 0;
            end
        end
    endtask

    // longest pattern plus margin, so the next beep starts from silence
    task automatic wait_buzzer_idle();
        repeat (3 * BEEP_LEN + 2) @(posedge clk);
        #1;
        assert (buzzer == 1'b0) else report_fail("buzzer high after its pattern ended");
    endtask

    task automatic wait_buzzer_toggle();
        logic start_level;
        int   cycles;
        start_level = buzzer;
        cycles      = 0;
        while (buzzer == start_level) begin
            if (cycles == BEEP_LEN) begin
                report_timeout("the buzzer to toggle after an accepted key");
            end
            @(posedge clk);
            #1;
            cycles++;
        end
    endtask

    // called 1 ns after a rising edge, returns at the same phase
    task automatic press(input int key);
        logic tone;
        logic was_lockout;
        was_lockout = (exp_mode == lock_pkg::ST_LOCKOUT);
        model_key(key, tone);
        if (tone) begin
            wait_buzzer_idle();
        end
        onehot = 16'(1) << key;
        repeat (3) @(posedge clk); // sync, event, state update
        #1;
        check_outputs("after press");
        if (!was_lockout && exp_mode == lock_pkg::ST_LOCKOUT) begin
            @(posedge clk);
            #1;
            assert (display.digit == {4'h0, SECS_BCD}) else report_fail($sformatf(
                "lockout seconds %h, expected %h", display.digit, SECS_BCD));
        end
        if (tone) begin
            wait_buzzer_toggle();
        end
        repeat (3) @(posedge clk);
        #1;
        onehot = '0;
        repeat (6) @(posedge clk);
        #1;
        check_outputs("after release"); // a held key must not repeat
    endtask

    task automatic enter_code(input logic [11:0] code);
        press(int'(code[11:8]));
        press(int'(code[7:4]));
        press(int'(code[3:0]));
        press(keypad_pkg::KEY_ENTER);
    endtask

    task automatic pick_code(output logic [11:0] code);
        code = exp_code;
        while (code == exp_code) begin
            for (int i = 0; i < 3; i++) begin
                rng_state = xorshift32(rng_state);
                code      = {code[7:0], 4'(rng_state % 10)};
            end
        end
    endtask

    task automatic wait_lockout_end();
        int cycles;
        cycles = 0;
        while (display.mode != lock_pkg::ST_ENTRY) begin
            if (cycles == LOCKOUT_SECS * TICK_DIV + 10) begin
                report_timeout("the lockout countdown to finish");
            end
            @(posedge clk);
            #1;
            cycles++;
        end
        exp_mode = lock_pkg::ST_ENTRY;
        check_outputs("after lockout");
    endtask

    initial begin
        reset        = 1'b1;
        onehot       = '0;
        rng_state    = 32'h88dd_a873;
        exp_mode     = lock_pkg::ST_ENTRY;
        exp_buf      = '0;
        exp_count    = 0;
        exp_tries    = 0;
        exp_unlocked = 1'b0;
        exp_code     = DEFAULT_CODE;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        check_outputs("after reset");

        // digit entry, back-space, overflow and clear
        press(1);
        press(2);
        press(keypad_pkg::KEY_BACK);
        press(3);
        press(4);
        press(5); // fourth digit dropped
        press(keypad_pkg::KEY_BACK);
        press(keypad_pkg::KEY_CLEAR);

        // short code ignored, then the default code opens
        press(2);
        press(4);
        press(keypad_pkg::KEY_ENTER);
        press(keypad_pkg::KEY_CLEAR);
        enter_code(DEFAULT_CODE);
        press(keypad_pkg::KEY_CLEAR);

        // wrong codes up to lockout
        for (int i = 0; i < MAX_TRIES; i++) begin
            pick_code(new_code);
            enter_code(new_code);
        end
        press(7);
        press(keypad_pkg::KEY_ENTER);
        wait_lockout_end();

        // abandon a new code, then store one
        old_code = exp_code;
        enter_code(old_code);
        press(keypad_pkg::KEY_SET);
        press(9);
        press(keypad_pkg::KEY_CLEAR);
        press(keypad_pkg::KEY_SET);
        pick_code(new_code);
        enter_code(new_code);
        press(keypad_pkg::KEY_CLEAR);
        enter_code(old_code); // old code now fails
        enter_code(new_code);
        press(keypad_pkg::KEY_CLEAR);

        // let the last pattern run out
        repeat (3 * BEEP_LEN + 10) @(posedge clk);
        #1;
        assert (buzzer == 1'b0) else report_fail("buzzer high while idle");

        $display("all tests passed");
        $finish;
    end

endmodule

//--- dv/lock_asserts.sv
`timescale 1ns/10ps

module lock_asserts #(
    parameter int unsigned BEEP_LEN = 40
) (
    input logic                   clk,
    input logic                   reset,
    input keypad_pkg::key_event_t key_event,
    input logic                   lockout_start,
    input lock_pkg::display_t     display,
    input lock_pkg::tone_req_t    tone_req,
    input logic                   buzzer
);

    localparam int unsigned QUIET = 3 * BEEP_LEN; // longest pattern length

    logic [31:0] idle_q; // cycles since the last tone request, saturating

    always_ff @(posedge clk) begin
        if (reset) begin
            idle_q <= '0;
        end else if (tone_req.valid) begin
            idle_q <= '0;
        end else if (idle_q < QUIET) begin
            idle_q <= idle_q + 32'd1;
        end
    end

    key_pulse_single: assert property (@(posedge clk) disable iff (reset)
        key_event.valid |=> !key_event.valid)
        else $error("key event valid high for two cycles in a row");

    lockout_from_entry: assert property (@(posedge clk) disable iff (reset)
        lockout_start |-> $past(display.mode) == lock_pkg::ST_ENTRY)
        else $error("lockout started outside of code entry");

    buzzer_quiet: assert property (@(posedge clk) disable iff (reset)
        (idle_q >= QUIET) |-> !buzzer)
        else $error("buzzer still sounding after the pattern ended");

endmodule

bind lock_top lock_asserts #(
    .BEEP_LEN (BEEP_LEN)
) lock_asserts_inst (
    .clk           (clk),
    .reset         (reset),
    .key_event     (key_event),
    .lockout_start (lockout_start),
    .display       (display),
    .tone_req      (tone_req),
    .buzzer        (buzzer)
);

//--- rtl/lock_top.sv
`timescale 1ns/10ps

module lock_top #(
    parameter int unsigned TICK_DIV     = 50_000_000,
    parameter int unsigned LOCKOUT_SECS = 30,
    parameter int unsigned MAX_TRIES    = 3,
    parameter logic [11:0] DEFAULT_CODE = 12'h246,
    parameter int unsigned TONE_HALF    = 25_000,
    parameter int unsigned BEEP_LEN     = 10_000_000
) (
    input  logic               clk,
    input  logic               reset,
    input  logic [15:0]        onehot,
    output lock_pkg::display_t display,
    output logic [3:0]         tries,
    output logic               unlocked,
    output logic               buzzer
);

    keypad_pkg::key_event_t key_event;
    lock_pkg::tone_req_t    tone_req;
    logic                   lockout_start;
    logic [7:0]             secs_left;
    logic                   tick;
    logic                   done;

    keypad_decoder keypad_decoder_inst (
        .clk       (clk),
        .reset     (reset),
        .onehot    (onehot),
        .key_event (key_event)
    );

    code_entry #(
        .MAX_TRIES    (MAX_TRIES),
        .DEFAULT_CODE (DEFAULT_CODE)
    ) code_entry_inst (
        .clk           (clk),
        .reset         (reset),
        .key_event     (key_event),
        .secs_left     (secs_left),
        .tick          (tick),
        .done          (done),
        .display       (display),
        .tries         (tries),
        .unlocked      (unlocked),
        .lockout_start (lockout_start),
        .tone_req      (tone_req)
    );

    lockout_timer #(
        .TICK_DIV     (TICK_DIV),
        .LOCKOUT_SECS (LOCKOUT_SECS)
    ) lockout_timer_inst (
        .clk       (clk),
        .reset     (reset),
        .start     (lockout_start),
        .secs_left (secs_left),
        .tick      (tick),
        .done      (done)
    );

    buzzer_tone #(
        .TONE_HALF (TONE_HALF),
        .BEEP_LEN  (BEEP_LEN)
    ) buzzer_tone_inst (
        .clk      (clk),
        .reset    (reset),
        .tone_req (tone_req),
        .buzzer   (buzzer)
    );

endmodule

//--- rtl/buzzer_tone.sv
`timescale 1ns/10ps

module buzzer_tone #(
    parameter int unsigned TONE_HALF = 25_000,
    parameter int unsigned BEEP_LEN  = 10_000_000
) (
    input  logic                clk,
    input  logic                reset,
    input  lock_pkg::tone_req_t tone_req,
    output logic                buzzer
);

    localparam int unsigned LW = $clog2(3 * BEEP_LEN + 1);
    localparam int unsigned HW = $clog2(2 * TONE_HALF + 1);

    lock_pkg::tone_e pattern_q;
    logic            active_q;
    logic            phase_q;   // square wave level
    logic [LW-1:0]   len_q;
    logic [HW-1:0]   half_q;
    logic [LW-1:0]   len_end;
    logic [HW-1:0]   half_end;
    logic            silent;

    always_comb begin
        case (pattern_q)
            lock_pkg::TONE_SUCCESS: begin
                half_end = HW'(TONE_HALF / 2); // higher pitch
                len_end  = LW'(3 * BEEP_LEN);
            end
            lock_pkg::TONE_FAIL: begin
                half_end = HW'(2 * TONE_HALF); // lower pitch
                len_end  = LW'(3 * BEEP_LEN);
            end
            default: begin
                half_end = HW'(TONE_HALF);
                len_end  = LW'(BEEP_LEN);
            end
        endcase
    end

    // middle unit of the fail pattern is quiet
    assign silent = (pattern_q == lock_pkg::TONE_FAIL) && (len_q >= LW'(BEEP_LEN))
                    && (len_q < LW'(2 * BEEP_LEN));
    assign buzzer = active_q && phase_q && !silent;

    always_ff @(posedge clk) begin
        if (reset) begin
            pattern_q <= lock_pkg::TONE_CLICK;
            active_q  <= 1'b0;
            phase_q   <= 1'b0;
            len_q     <= '0;
            half_q    <= '0;
        end else if (tone_req.valid) begin
            pattern_q <= tone_req.tone; // restart with new pattern
            active_q  <= 1'b1;
            phase_q   <= 1'b1;
            len_q     <= '0;
            half_q    <= '0;
        end else if (active_q) begin
            len_q  <= len_q + LW'(1);
            half_q <= half_q + HW'(1);
            if (half_q == half_end - HW'(1)) begin
                half_q  <= '0;
                phase_q <= !phase_q;
            end
            if (len_q == len_end - LW'(1)) begin
                active_q <= 1'b0;
                phase_q  <= 1'b0;
            end
        end
    end

endmodule

//--- rtl/lockout_timer.sv
`timescale 1ns/10ps

module lockout_timer #(
    parameter int unsigned TICK_DIV     = 50_000_000,
    parameter int unsigned LOCKOUT_SECS = 30
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       start,
    output logic [7:0] secs_left, // two BCD digits
    output logic       tick,
    output logic       done
);

    localparam int unsigned DW = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;
    localparam logic [7:0] SECS_BCD = {4'(LOCKOUT_SECS / 10), 4'(LOCKOUT_SECS % 10)};

    logic [DW-1:0] div_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            div_q     <= '0;
            secs_left <= '0;
            tick      <= 1'b0;
            done      <= 1'b0;
        end else begin
            tick <= 1'b0;
            done <= 1'b0;
            if (start) begin
                secs_left <= SECS_BCD;
                div_q     <= '0;
            end else if (secs_left != 8'h00) begin
                if (div_q == DW'(TICK_DIV - 1)) begin
                    div_q <= '0;
                    tick  <= 1'b1;
                    if (secs_left[3:0] == 4'h0) begin
                        secs_left <= {secs_left[7:4] - 4'h1, 4'h9}; // decimal borrow
                    end else begin
                        secs_left[3:0] <= secs_left[3:0] - 4'h1;
                    end
                    done <= (secs_left == 8'h01); // last second
                end else begin
                    div_q <= div_q + DW'(1);
                end
            end
        end
    end

endmodule

//--- rtl/code_entry.sv
`timescale 1ns/10ps

module code_entry #(
    parameter int unsigned MAX_TRIES    = 3,
    parameter logic [11:0] DEFAULT_CODE = 12'h246
) (
    input  logic                   clk,
    input  logic                   reset,
    input  keypad_pkg::key_event_t key_event,
    input  logic [7:0]             secs_left,
    input  logic                   tick,
    input  logic                   done,
    output lock_pkg::display_t     display,
    output logic [3:0]             tries,
    output logic                   unlocked,
    output logic                   lockout_start,
    output lock_pkg::tone_req_t    tone_req
);

    lock_pkg::lock_state_e state_q;
    logic [2:0][3:0]       buf_q;    // entered digits, [0] newest
    logic [1:0]            count_q;
    logic [11:0]           code_q;   // stored combination
    logic                  is_digit;
    logic                  can_type;

    assign is_digit = key_event.key <= keypad_pkg::KEY_9;
    assign can_type = (state_q == lock_pkg::ST_ENTRY) || (state_q == lock_pkg::ST_SET);

    always_comb begin
        display.mode  = state_q;
        display.count = count_q;
        if (state_q == lock_pkg::ST_LOCKOUT) begin
            display.digit = {4'h0, secs_left}; // seconds remaining
        end else begin
            display.digit = buf_q;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q       <= lock_pkg::ST_ENTRY;
            buf_q         <= '0;
            count_q       <= '0;
            code_q        <= DEFAULT_CODE;
            tries         <= '0;
            unlocked      <= 1'b0;
            lockout_start <= 1'b0;
            tone_req      <= '0;
        end else begin
            lockout_start  <= 1'b0;
            tone_req.valid <= 1'b0;
            if (state_q == lock_pkg::ST_LOCKOUT) begin
                if (tick) begin
                    tone_req <= '{valid: 1'b1, tone: lock_pkg::TONE_CLICK};
                end
                if (done) begin
                    state_q <= lock_pkg::ST_ENTRY;
                end
            end else if (key_event.valid) begin
                if (is_digit && can_type) begin
                    if (count_q < 2'd3) begin
                        buf_q   <= {buf_q[1:0], 4'(key_event.key)};
                        count_q <= count_q + 2'd1;
                    end
                    tone_req <= '{valid: 1'b1, tone: lock_pkg::TONE_CLICK};
                end else if (key_event.key == keypad_pkg::KEY_BACK && can_type) begin
                    buf_q <= {4'h0, buf_q[2:1]}; // drop newest digit
                    if (count_q != 2'd0) begin
                        count_q <= count_q - 2'd1;
                    end
                    tone_req <= '{valid: 1'b1, tone: lock_pkg::TONE_CLICK};
                end else if (key_event.key == keypad_pkg::KEY_ENTER && can_type
                             && count_q == 2'd3) begin
                    buf_q   <= '0;
                    count_q <= '0;
                    if (state_q == lock_pkg::ST_SET) begin
                        code_q   <= buf_q; // new combination
                        state_q  <= lock_pkg::ST_OPEN;
                        tone_req <= '{valid: 1'b1, tone: lock_pkg::TONE_SUCCESS};
                    end else if (buf_q == code_q) begin
                        state_q  <= lock_pkg::ST_OPEN;
                        tries    <= '0;
                        unlocked <= 1'b1;
                        tone_req <= '{valid: 1'b1, tone: lock_pkg::TONE_SUCCESS};
                    end else begin
                        tone_req <= '{valid: 1'b1, tone: lock_pkg::TONE_FAIL};
                        if (tries + 4'd1 == 4'(MAX_TRIES)) begin
                            state_q       <= lock_pkg::ST_LOCKOUT;
                            lockout_start <= 1'b1;
                            tries         <= '0;
                        end else begin
                            tries <= tries + 4'd1;
                        end
                    end
                end else if (key_event.key == keypad_pkg::KEY_CLEAR) begin
                    buf_q    <= '0;
                    count_q  <= '0;
                    tone_req <= '{valid: 1'b1, tone: lock_pkg::TONE_CLICK};
                    case (state_q)
                        lock_pkg::ST_ENTRY: tries <= '0;
                        lock_pkg::ST_OPEN: begin
                            state_q  <= lock_pkg::ST_ENTRY; // relock
                            unlocked <= 1'b0;
                        end
                        default: state_q <= lock_pkg::ST_OPEN; // abandon new code
                    endcase
                end else if (key_event.key == keypad_pkg::KEY_SET
                             && state_q == lock_pkg::ST_OPEN) begin
                    state_q  <= lock_pkg::ST_SET;
                    buf_q    <= '0;
                    count_q  <= '0;
                    tone_req <= '{valid: 1'b1, tone: lock_pkg::TONE_CLICK};
                end
            end
        end
    end

endmodule

//--- rtl/keypad_decoder.sv
`timescale 1ns/10ps

module keypad_decoder (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [15:0]             onehot,
    output keypad_pkg::key_event_t  key_event
);

    logic [15:0]      sync_q;  // registered keypad levels
    logic [15:0]      prev_q;  // value seen one cycle earlier
    logic             key_ok;
    keypad_pkg::key_e key_code;

    // exactly one bit among the used keys
    assign key_ok = $onehot(sync_q) && (sync_q[15:14] == 2'b00);

    always_comb begin
        key_code = keypad_pkg::KEY_0;
        for (int i = 0; i < keypad_pkg::NUM_KEYS; i++) begin
            if (sync_q[i]) begin
                key_code = keypad_pkg::key_e'(i); // bit index is the key
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            sync_q    <= '0;
            prev_q    <= '0;
            key_event <= '0;
        end else begin
            sync_q          <= onehot;
            prev_q          <= sync_q;
            key_event.valid <= key_ok && (sync_q != prev_q); // held key fires once
            key_event.key   <= key_code;
        end
    end

endmodule

//--- rtl/lock_pkg.sv
package lock_pkg;

    typedef enum logic [1:0] {
        ST_ENTRY   = 2'd0,
        ST_SET     = 2'd1,
        ST_OPEN    = 2'd2,
        ST_LOCKOUT = 2'd3
    } lock_state_e;

    typedef enum logic [1:0] {
        TONE_CLICK   = 2'd0,
        TONE_SUCCESS = 2'd1,
        TONE_FAIL    = 2'd2
    } tone_e;

    typedef struct packed {
        logic  valid; // one-cycle pulse
        tone_e tone;
    } tone_req_t;

    // digit[2] is the oldest entered digit
    typedef struct packed {
        logic [2:0][3:0] digit;
        logic [1:0]      count;
        lock_state_e     mode;
    } display_t;

endpackage

//--- rtl/keypad_pkg.sv
package keypad_pkg;

    // enum value equals the one-hot bit position of the key
    typedef enum logic [3:0] {
        KEY_0     = 4'd0,
        KEY_1     = 4'd1,
        KEY_2     = 4'd2,
        KEY_3     = 4'd3,
        KEY_4     = 4'd4,
        KEY_5     = 4'd5,
        KEY_6     = 4'd6,
        KEY_7     = 4'd7,
        KEY_8     = 4'd8,
        KEY_9     = 4'd9,
        KEY_ENTER = 4'd10,
        KEY_BACK  = 4'd11,
        KEY_CLEAR = 4'd12,
        KEY_SET   = 4'd13
    } key_e;

    localparam int unsigned NUM_KEYS = 14; // bits 14 and 15 unused

    typedef struct packed {
        logic valid; // one-cycle pulse per press
        key_e key;
    } key_event_t;

endpackage
